// ==== src.f ====
verilog/osf_cfg_pkg.sv
verilog/osf_state_pkg.sv
verilog/param_latch.sv
verilog/oversample_filter.sv
verilog/output_saturate.sv
verilog/osf_channel.sv
test/osf_channel_checker.sv
test/osf_channel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with assertions on, run into sim.log, then scan the log for the verdict
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -j 0 --top-module osf_channel_tb -f src.f -o osf_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/osf_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"

// ==== test/osf_channel_tb.sv ====
module osf_channel_tb;

	localparam int          W_IN     = 18;
	localparam int          W_OUT    = 16;
	localparam int          LIM_HI   = 2 ** (W_OUT - 1) - 1;
	localparam int          LIM_LO   = -(2 ** (W_OUT - 1));
	localparam int          SPAN_IN  = 2 ** (W_IN - 1) - 1;	// full input swing
	localparam int          WAIT_MAX = 20;	// cycles per wait loop
	localparam int unsigned SEED     = 32'hec81;

	logic                            clk_in;
	logic                            osf_reset;
	logic signed [W_IN-1:0]          data;
	logic                            data_valid;
	logic [osf_cfg_pkg::DELAY_W-1:0] cycle_delay;
	logic [osf_cfg_pkg::OSM_W-1:0]   osm;
	logic                            update_en;
	logic                            update;
	logic                            activate;
	logic signed [W_OUT-1:0]         out_data;
	logic                            out_valid;
	logic                            overflow;

	int unsigned lcg;	// generator state
	int errors   = 0;	// wrong values
	int timeouts = 0;
	int blocks   = 0;	// strobes the model expects
	int seen     = 0;	// strobes on the port
	int mdl_osm;		// settings in force, model copy
	int mdl_delay;

	osf_channel #(.W_IN(W_IN), .W_OUT(W_OUT)) UUT (.*);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;
	end

	always @(negedge clk_in) begin
		if (out_valid) seen++;	// wanted or not
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic int unsigned lcg_next();
		lcg = lcg * 32'd1664525 + 32'd1013904223;
		return lcg;
	endfunction

	function automatic int rand_in(input int span);
		int unsigned r;
		r = (lcg_next() >> 8) % (2 * span + 1);
		return int'(r) - span;	// -span .. span
	endfunction

	function automatic int rand_gap();
		return int'((lcg_next() >> 8) % 3);	// idle cycles between strobes
	endfunction

	task automatic compare(input string name, input longint expected, input longint actual);
		assert (expected == actual) else begin
			errors++;
			$display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic put_sample(input int value, input int gap);
		data       = value[W_IN-1:0];
		data_valid = 1'b1;
		@(negedge clk_in);
		data_valid = 1'b0;
		repeat (gap) @(negedge clk_in);
	endtask

	// DUT latches only when en and pulse are both high
	task automatic panel_write(input int new_osm, input int new_delay, input logic en,
			input logic pulse);
		osm         = new_osm[osf_cfg_pkg::OSM_W-1:0];
		cycle_delay = new_delay[osf_cfg_pkg::DELAY_W-1:0];
		update_en   = en;
		update      = pulse;
		@(negedge clk_in);
		update    = 1'b0;
		update_en = 1'b0;
		if (en && pulse) begin
			mdl_osm   = new_osm;
			mdl_delay = new_delay;
		end
	endtask

	task automatic set_active(input logic on);
		activate = on;
		@(negedge clk_in);	// ST_IDLE cycle, no sample here
	endtask

	////////////////////////////////////////////////////////////
	// one block, its mean, then the settling skip
	////////////////////////////////////////////////////////////

	// span 0 repeats fixed, new_osm >= 0 writes the panel after the first sample
	task automatic run_block(input int span, input int fixed, input int new_osm);
		int     i;
		int     n;
		int     v;
		int     shift;
		int     waited;
		longint sum;
		longint mean;
		shift = mdl_osm;	// running block keeps its osm
		n     = 1 << shift;
		sum   = 0;
		for (i = 0; i < n; i++) begin
			v = (span == 0) ? fixed : rand_in(span);
			sum += v;
			put_sample(v, (i == n - 1) ? 0 : rand_gap());
			if (i == 0 && n > 1 && new_osm >= 0) begin
				panel_write(new_osm, mdl_delay, 1'b1, 1'b1);
			end
		end
		waited = 1;	// one falling edge past the last sample
		while (!out_valid && waited < WAIT_MAX) begin
			@(negedge clk_in);
			waited++;
		end
		if (!out_valid) begin
			timeouts++;
			$display("timeout: no out_valid within %0d cycles of a block end", WAIT_MAX);
		end else begin
			blocks++;
			mean = sum >>> shift;	// floor division by 2^osm
			compare("out_valid latency", 2, waited);
			compare("out_data", (mean > LIM_HI) ? LIM_HI : (mean < LIM_LO) ? LIM_LO : mean,
				out_data);
			compare("overflow", (mean > LIM_HI) || (mean < LIM_LO), overflow);
		end
		if (mdl_delay == 0) begin
			@(negedge clk_in);	// lone ST_DELAY cycle drops strobes
		end else begin
			for (i = 0; i < mdl_delay; i++) begin
				put_sample(rand_in(SPAN_IN), rand_gap());	// junk, must stay out of sums
			end
		end
	endtask

	task automatic abort_block(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			put_sample(rand_in(SPAN_IN), rand_gap());
		end
		activate = 1'b0;	// partial sum is dropped
		for (i = 0; i < 6; i++) begin
			put_sample(rand_in(SPAN_IN), 0);	// enough strobes to finish the block if kept
			compare("out_valid", 0, out_valid);
		end
	endtask

	////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		int total;
		lcg         = SEED;
		osf_reset   = 1'b1;
		data        = '0;
		data_valid  = 1'b0;
		cycle_delay = '0;
		osm         = '0;
		update_en   = 1'b0;
		update      = 1'b0;
		activate    = 1'b0;
		mdl_osm     = 0;
		mdl_delay   = 0;
		repeat (5) @(negedge clk_in);
		osf_reset = 1'b0;
		repeat (4) @(negedge clk_in);	// channel still off

		panel_write(2, 0, 1'b1, 1'b1);
		set_active(1'b1);
		for (i = 0; i < 3; i++) run_block(40000, 0, -1);
		panel_write(5, 7, 1'b0, 1'b1);	// no enable
		panel_write(4, 9, 1'b1, 1'b0);	// no pulse
		for (i = 0; i < 2; i++) run_block(40000, 0, -1);
		run_block(40000, 0, 5);	// osm 5 from the next block on
		for (i = 0; i < 2; i++) run_block(40000, 0, -1);

		set_active(1'b0);
		panel_write(0, 0, 1'b1, 1'b1);
		set_active(1'b1);
		for (i = 0; i < 6; i++) run_block(40000, 0, -1);

		// settling delay, first block after activation skips none
		set_active(1'b0);
		panel_write(2, 3, 1'b1, 1'b1);
		set_active(1'b1);
		for (i = 0; i < 4; i++) run_block(40000, 0, -1);

		// clamp to 16 bits
		set_active(1'b0);
		panel_write(0, 0, 1'b1, 1'b1);
		set_active(1'b1);
		run_block(0, SPAN_IN, -1);
		run_block(0, -SPAN_IN - 1, -1);
		run_block(0, LIM_HI + 1, -1);
		run_block(0, LIM_LO - 1, -1);
		run_block(0, LIM_HI, -1);
		run_block(0, LIM_LO, -1);

		// switch off mid-block, settings survive
		set_active(1'b0);
		panel_write(3, 3, 1'b1, 1'b1);
		set_active(1'b1);
		run_block(40000, 0, -1);
		abort_block(5);
		set_active(1'b1);
		for (i = 0; i < 2; i++) run_block(40000, 0, -1);

		assert (seen == blocks) else begin
			errors++;
			$display("out_valid fired %0d times for %0d completed blocks", seen, blocks);
		end
		total = errors + timeouts + int'(UUT.chk.fails);
		$display("errors: %0d wrong values, %0d timeouts, %0d checker assertions",
			errors, timeouts, UUT.chk.fails);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== test/osf_channel_checker.sv ====
module osf_channel_checker (
	input logic                      clk_in,
	input logic                      osf_reset,
	input logic                      activate,
	input logic                      out_valid,
	input logic                      overflow,
	input osf_state_pkg::osf_state_t filt_state	// filter fsm, reached through bind
);

	int unsigned fails = 0;	// summed into the testbench verdict

	logic in_send;	// filter presents a mean this cycle

	assign in_send = (filt_state == osf_state_pkg::ST_SEND);

	////////////////////////////////////////////////////////////
	// quiet outputs
	////////////////////////////////////////////////////////////

	// one edge after reset nothing shows
	reset_quiet: assert property (@(posedge clk_in)
		$past(osf_reset) |-> !out_valid && !overflow)
	else begin
		fails++;
		$error("out_valid or overflow high right after osf_reset");
	end

	// two edges with activate low flush the pipe
	idle_quiet: assert property (@(posedge clk_in) disable iff (osf_reset)
		$past(!activate, 2) |-> !out_valid && !overflow)
	else begin
		fails++;
		$error("out_valid or overflow high while the channel is off");
	end

	overflow_with_valid: assert property (@(posedge clk_in)
		overflow |-> out_valid)
	else begin
		fails++;
		$error("overflow seen without out_valid");
	end

	////////////////////////////////////////////////////////////
	// strobe timing
	////////////////////////////////////////////////////////////

	single_strobe: assert property (@(posedge clk_in) disable iff (osf_reset)
		out_valid |-> !$past(out_valid))
	else begin
		fails++;
		$error("out_valid wider than one cycle");
	end

	// clamp stage is one register behind ST_SEND
	valid_after_send: assert property (@(posedge clk_in) disable iff (osf_reset)
		out_valid |-> $past(in_send))
	else begin
		fails++;
		$error("out_valid without ST_SEND in the cycle before");
	end

	send_one_cycle: assert property (@(posedge clk_in) disable iff (osf_reset)
		$past(in_send) |-> out_valid && !in_send)
	else begin
		fails++;
		$error("ST_SEND not followed by a single out_valid");
	end

endmodule

bind osf_channel osf_channel_checker chk (
	.clk_in     (clk_in),
	.osf_reset  (osf_reset),
	.activate   (activate),
	.out_valid  (out_valid),
	.overflow   (overflow),
	.filt_state (u_oversample_filter.state)
);

// ==== verilog/osf_channel.sv ====
module osf_channel #(
	parameter int W_IN  = 18,	// controller sample width
	parameter int W_OUT = 16	// output width toward the DAC
)(
	input  logic                                 clk_in,
	input  logic                                 osf_reset,

	// controller core
	input  logic signed [W_IN-1:0]               data,
	input  logic                                 data_valid,

	// front panel
	input  logic [osf_cfg_pkg::DELAY_W-1:0]      cycle_delay,
	input  logic [osf_cfg_pkg::OSM_W-1:0]        osm,
	input  logic                                 update_en,
	input  logic                                 update,
	input  logic                                 activate,

	// toward the DAC side
	output logic signed [W_OUT-1:0]              out_data,
	output logic                                 out_valid,
	output logic                                 overflow
);

	////////////////////////////////////////////////////////////
	// stage wiring
	////////////////////////////////////////////////////////////

	osf_cfg_pkg::osf_cfg_t                                  cfg;			// latch -> filter
	logic signed [W_IN+osf_state_pkg::SUM_EXTRA-1:0]        mean;		// filter -> clamp
	logic                                                   mean_valid;

	param_latch u_param_latch (
		.clk_in      (clk_in),
		.osf_reset   (osf_reset),
		.cycle_delay (cycle_delay),
		.osm         (osm),
		.update_en   (update_en),
		.update      (update),
		.cfg         (cfg)
	);

	oversample_filter #(
		.W_IN (W_IN)
	) u_oversample_filter (
		.clk_in     (clk_in),
		.osf_reset  (osf_reset),
		.activate   (activate),
		.data       (data),
		.data_valid (data_valid),
		.cfg        (cfg),
		.mean       (mean),
		.mean_valid (mean_valid)
	);

	output_saturate #(
		.W_IN  (W_IN),
		.W_OUT (W_OUT)
	) u_output_saturate (
		.clk_in     (clk_in),
		.osf_reset  (osf_reset),
		.mean       (mean),
		.mean_valid (mean_valid),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.overflow   (overflow)
	);

endmodule

// ==== verilog/output_saturate.sv ====
module output_saturate #(
	parameter int W_IN  = 18,	// filter input width, sets the mean width
	parameter int W_OUT = 16	// DAC side width
)(
	input  logic                                              clk_in,
	input  logic                                              osf_reset,
	input  logic signed [W_IN+osf_state_pkg::SUM_EXTRA-1:0]   mean,
	input  logic                                              mean_valid,
	output logic signed [W_OUT-1:0]                           out_data,	// held between strobes
	output logic                                              out_valid,
	output logic                                              overflow	// clamp happened
);

	localparam int w_sum = W_IN + osf_state_pkg::SUM_EXTRA;

	// signed W_OUT range, in mean width
	localparam logic signed [w_sum-1:0] lim_hi = w_sum'(2 ** (W_OUT - 1) - 1);
	localparam logic signed [w_sum-1:0] lim_lo = -lim_hi - 1;

	logic over_hi;	// above positive limit
	logic over_lo;	// below negative limit

	assign over_hi = (mean > lim_hi);
	assign over_lo = (mean < lim_lo);

	////////////////////////////////////////////////////////////
	// registered clamp
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (mean_valid) begin
			if (over_hi)      out_data <= lim_hi[W_OUT-1:0];
			else if (over_lo) out_data <= lim_lo[W_OUT-1:0];
			else              out_data <= mean[W_OUT-1:0];	// fits, drop sign copies
		end
	end

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			out_valid <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			out_valid <= mean_valid;	// one cycle behind the filter
			overflow  <= mean_valid & (over_hi | over_lo);	// only with out_valid
		end
	end

endmodule

// ==== verilog/oversample_filter.sv ====
module oversample_filter #(
	parameter int W_IN = 18	// sample width from the controller core
)(
	input  logic                                              clk_in,
	input  logic                                              osf_reset,
	input  logic                                              activate,	// low clears the filter
	input  logic signed [W_IN-1:0]                            data,
	input  logic                                              data_valid,	// irregular strobe
	input  osf_cfg_pkg::osf_cfg_t                             cfg,
	output logic signed [W_IN+osf_state_pkg::SUM_EXTRA-1:0]   mean,		// not narrowed
	output logic                                              mean_valid
);

	localparam int w_sum = W_IN + osf_state_pkg::SUM_EXTRA;	// accumulator width
	localparam int w_cnt = osf_cfg_pkg::DELAY_W;				// covers 2^MAX_OSM too

	osf_state_pkg::osf_state_t state;
	osf_state_pkg::osf_state_t state_nxt;

	logic                            clr;		// reset or channel off
	logic [w_cnt-1:0]                cnt;		// valid strobes seen in this state
	logic [w_cnt-1:0]                blk_max;	// 2^osm - 1
	logic [osf_cfg_pkg::OSM_W-1:0]   osm_blk;	// osm of the running block
	logic signed [w_sum-1:0]         sum;
	logic                            blk_done;	// last sample of block accepted
	logic                            dly_done;	// settling skip finished

	assign clr = osf_reset | ~activate;

	////////////////////////////////////////////////////////////
	// block length and skip count
	////////////////////////////////////////////////////////////

	assign blk_max  = (w_cnt'(1) << osm_blk) - 1'b1;
	assign blk_done = data_valid && (cnt == blk_max);

	// zero delay leaves ST_DELAY on the next edge
	assign dly_done = (cfg.cycle_delay == '0) ||
		(data_valid && (cnt == cfg.cycle_delay - 1'b1));

	// osm frozen while a block runs, a mid-block update waits for the next one
	always_ff @(posedge clk_in) begin
		if (state == osf_state_pkg::ST_IDLE || state == osf_state_pkg::ST_DELAY) begin
			osm_blk <= cfg.osm;
		end
	end

	////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clr) begin
			state <= osf_state_pkg::ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;	// hold by default
		case (state)
			osf_state_pkg::ST_IDLE: begin
				state_nxt = osf_state_pkg::ST_SAMPLE;	// clr covers activate low
			end
			osf_state_pkg::ST_SAMPLE: begin
				if (blk_done) state_nxt = osf_state_pkg::ST_SEND;
			end
			osf_state_pkg::ST_SEND: begin
				state_nxt = osf_state_pkg::ST_DELAY;	// exactly one cycle
			end
			osf_state_pkg::ST_DELAY: begin
				if (dly_done) state_nxt = osf_state_pkg::ST_SAMPLE;
			end
			default: state_nxt = osf_state_pkg::ST_IDLE;
		endcase
	end

	// counts accepted or skipped strobes, restarts on every state change
	always_ff @(posedge clk_in) begin
		if (clr) begin
			cnt <= '0;
		end else if (state != state_nxt) begin
			cnt <= '0;
		end else if (data_valid) begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// accumulator and divide by shift
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (clr) begin
			sum <= '0;	// partial block discarded
		end else if (state == osf_state_pkg::ST_SAMPLE) begin
			if (data_valid) begin
				sum <= sum + {{osf_state_pkg::SUM_EXTRA{data[W_IN-1]}}, data};	// sign extend
			end
		end else if (state != osf_state_pkg::ST_SEND) begin
			sum <= '0;	// idle and delay start the next block clean
		end
	end

	assign mean       = sum >>> osm_blk;	// arithmetic, rounds toward -inf
	assign mean_valid = (state == osf_state_pkg::ST_SEND);

endmodule

// ==== verilog/param_latch.sv ====
module param_latch (
	input  logic                                 clk_in,
	input  logic                                 osf_reset,
	input  logic [osf_cfg_pkg::DELAY_W-1:0]      cycle_delay,	// from front panel
	input  logic [osf_cfg_pkg::OSM_W-1:0]        osm,			// from front panel
	input  logic                                 update_en,	// arms the update pulse
	input  logic                                 update,		// one-cycle update strobe
	output osf_cfg_pkg::osf_cfg_t                cfg			// settings in force
);

	logic upd_take;	// enabled update seen this edge

	assign upd_take = update & update_en;

	////////////////////////////////////////////////////////////
	// settings register
	////////////////////////////////////////////////////////////

	// panel writes land here only when armed
	// activate is not an input, deactivation keeps the values
	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			cfg <= '0;	// osm 0, no settling delay
		end else if (upd_take) begin
			cfg.osm         <= osm;
			cfg.cycle_delay <= cycle_delay;	// used from the next cycle on
		end
	end

endmodule

// ==== verilog/osf_state_pkg.sv ====
package osf_state_pkg;

	////////////////////////////////////////////////////////////
	// filter fsm encoding
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,	// waiting for activate
		ST_SAMPLE = 2'd1,	// accumulating valid samples
		ST_SEND   = 2'd2,	// one cycle, mean presented
		ST_DELAY  = 2'd3	// dropping strobes while the DAC settles
	} osf_state_t;

	////////////////////////////////////////////////////////////
	// accumulator growth
	////////////////////////////////////////////////////////////

	// 2^MAX_OSM samples add at most MAX_OSM bits
	// sum width is W_IN + SUM_EXTRA
	localparam int SUM_EXTRA = osf_cfg_pkg::MAX_OSM;

endpackage

// ==== verilog/osf_cfg_pkg.sv ====
package osf_cfg_pkg;

	////////////////////////////////////////////////////////////
	// front-panel field widths
	////////////////////////////////////////////////////////////

	localparam int OSM_W   = 4;		// log2 oversample ratio field
	localparam int DELAY_W = 16;	// settling delay, in valid strobes
	localparam int MAX_OSM = 15;	// largest ratio is 2^15 samples

	////////////////////////////////////////////////////////////
	// settings in force
	////////////////////////////////////////////////////////////

	// only changed on an enabled update pulse
	// survives channel deactivation, cleared by osf_reset only
	typedef struct packed {
		logic [OSM_W-1:0]   osm;			// log2 of block length
		logic [DELAY_W-1:0] cycle_delay;	// strobes skipped after each block
	} osf_cfg_t;

endpackage
